//--- source/ni_pkg.sv
// NoC chimney package
// Widths, flit field positions, the system address map and the channel
// and state encodings shared by the manager-side network interface

package ni_pkg;

  //////////////////////////////////////////////////////////////////////
  // AXI4-Lite widths
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned AddrWidth   = 32;
  localparam int unsigned DataWidth   = 32;
  localparam int unsigned StrbWidth   = 4;
  localparam int unsigned ProtWidth   = 3;
  localparam int unsigned RespWidth   = 2;
  localparam int unsigned NodeIdWidth = 4;

  // Outstanding transactions per direction
  localparam int unsigned MaxTxns  = 4;
  localparam int unsigned CntWidth = 3;

  //////////////////////////////////////////////////////////////////////
  // Flit layout
  //////////////////////////////////////////////////////////////////////

  // Header holds dst, src and channel
  localparam int unsigned ChWidth    = 3;
  localparam int unsigned DstLsb     = 0;
  localparam int unsigned SrcLsb     = 4;
  localparam int unsigned ChLsb      = 8;
  localparam int unsigned HdrWidth   = ChLsb + ChWidth;
  localparam int unsigned PayloadLsb = HdrWidth;

  localparam int unsigned ReqPayloadWidth = 36;
  localparam int unsigned RspPayloadWidth = 34;
  localparam int unsigned ReqFlitWidth    = HdrWidth + ReqPayloadWidth;
  localparam int unsigned RspFlitWidth    = HdrWidth + RspPayloadWidth;

  // Field offsets inside the payload
  localparam int unsigned AxAddrLsb = 0;
  localparam int unsigned AxProtLsb = 32;
  localparam int unsigned WDataLsb  = 0;
  localparam int unsigned WStrbLsb  = 32;
  localparam int unsigned RDataLsb  = 0;
  localparam int unsigned RRespLsb  = 32;
  localparam int unsigned BRespLsb  = 0;

  //////////////////////////////////////////////////////////////////////
  // System address map
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned SamSelLsb   = 12;
  localparam int unsigned SamSelWidth = 2;

  // Entry 0 is selected by address bits 13:12 == 0
  localparam logic [3:0][NodeIdWidth-1:0] SamNodeTable = {4'h6, 4'h5, 4'h2, 4'h1};
  localparam logic [NodeIdWidth-1:0]      SamDefaultNode = 4'hF;

  // Channel opcode carried in every flit header
  typedef enum logic [ChWidth-1:0] {
    ChAw = 3'd0,
    ChW  = 3'd1,
    ChAr = 3'd2,
    ChB  = 3'd3,
    ChR  = 3'd4
  } axi_ch_e;

  typedef enum logic {
    SelAw = 1'b0,
    SelW  = 1'b1
  } aw_w_state_e;

endpackage

//--- source/ni_addr_decoder.sv
// Address decoder
// Maps a request address onto the destination node ID with the fixed
// system address map

`timescale 1ns/10ps

module ni_addr_decoder (
  input  logic [ni_pkg::AddrWidth-1:0]   addr_i,
  output logic [ni_pkg::NodeIdWidth-1:0] dst_o
);

  import ni_pkg::*;

  logic                   in_range;
  logic [SamSelWidth-1:0] sel;

  // Only the lowest four regions are mapped
  assign in_range = (addr_i[AddrWidth-1:SamSelLsb+SamSelWidth] == '0);

  // Region index
  assign sel = addr_i[SamSelLsb +: SamSelWidth];

  always_comb begin
    if (in_range) begin
      dst_o = SamNodeTable[sel];
    end else begin
      // Everything else goes to the default node
      dst_o = SamDefaultNode;
    end
  end

endmodule

//--- source/ni_txn_tracker.sv
// Outstanding transaction tracker
// Counts requests in flight for one direction and stalls a new request
// when it would let responses come back out of order

`timescale 1ns/10ps

module ni_txn_tracker (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic                           req_fire_i,
  input  logic [ni_pkg::NodeIdWidth-1:0] req_dst_i,
  input  logic                           rsp_fire_i,
  output logic                           stall_o
);

  import ni_pkg::*;

  logic [CntWidth-1:0]    cnt_q;
  logic [NodeIdWidth-1:0] dst_q;
  logic                   full;
  logic                   dst_mismatch;

  // Up/down counter where a request and a response in one cycle cancel out
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else if (req_fire_i && !rsp_fire_i) begin
      cnt_q <= cnt_q + 1'b1;
    end else if (!req_fire_i && rsp_fire_i) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // Destination of the most recent request
  always_ff @(posedge clk_i) begin
    if (req_fire_i) begin
      dst_q <= req_dst_i;
    end
  end

  assign full = (cnt_q == CntWidth'(MaxTxns));

  // A different target while anything is in flight could overtake it
  assign dst_mismatch = (cnt_q != '0) && (req_dst_i != dst_q);

  assign stall_o = full || dst_mismatch;

endmodule

//--- source/ni_aw_w_fsm.sv
// Write sequencer
// Alternates the write stream between AW and W so that each pair stays
// together on the request link, and keeps the AW route for the W flit

`timescale 1ns/10ps

module ni_aw_w_fsm (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic                           aw_fire_i,
  input  logic                           w_fire_i,
  input  logic [ni_pkg::NodeIdWidth-1:0] aw_dst_i,
  output ni_pkg::aw_w_state_e            state_o,
  output logic [ni_pkg::NodeIdWidth-1:0] w_dst_o
);

  import ni_pkg::*;

  aw_w_state_e            state_q;
  aw_w_state_e            state_d;
  logic [NodeIdWidth-1:0] w_dst_q;

  // Next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      SelAw: begin
        if (aw_fire_i) begin
          state_d = SelW;
        end
      end
      SelW: begin
        if (w_fire_i) begin
          state_d = SelAw;
        end
      end
      default: state_d = SelAw;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= SelAw;
    end else begin
      state_q <= state_d;
    end
  end

  // W follows the same route as its AW
  always_ff @(posedge clk_i) begin
    if (aw_fire_i) begin
      w_dst_q <= aw_dst_i;
    end
  end

  assign state_o = state_q;
  assign w_dst_o = w_dst_q;

endmodule

//--- source/ni_req_arbiter.sv
// Request flit packer and arbiter
// Builds AW, W and AR flits and shares the request link round-robin
// between the write and read streams, keeping each AW/W pair together

`timescale 1ns/10ps

module ni_req_arbiter (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  logic [ni_pkg::NodeIdWidth-1:0]  id_i,
  input  logic                            axi_awvalid_i,
  input  logic [ni_pkg::AddrWidth-1:0]    axi_awaddr_i,
  input  logic [ni_pkg::ProtWidth-1:0]    axi_awprot_i,
  output logic                            axi_awready_o,
  input  logic                            axi_wvalid_i,
  input  logic [ni_pkg::DataWidth-1:0]    axi_wdata_i,
  input  logic [ni_pkg::StrbWidth-1:0]    axi_wstrb_i,
  output logic                            axi_wready_o,
  input  logic                            axi_arvalid_i,
  input  logic [ni_pkg::AddrWidth-1:0]    axi_araddr_i,
  input  logic [ni_pkg::ProtWidth-1:0]    axi_arprot_i,
  output logic                            axi_arready_o,
  input  logic [ni_pkg::NodeIdWidth-1:0]  aw_dst_i,
  input  logic [ni_pkg::NodeIdWidth-1:0]  w_dst_i,
  input  logic [ni_pkg::NodeIdWidth-1:0]  ar_dst_i,
  input  logic                            wr_stall_i,
  input  logic                            rd_stall_i,
  input  ni_pkg::aw_w_state_e             state_i,
  output logic                            aw_fire_o,
  output logic                            w_fire_o,
  output logic                            ar_fire_o,
  output logic                            floo_req_valid_o,
  input  logic                            floo_req_ready_i,
  output logic [ni_pkg::ReqFlitWidth-1:0] floo_req_flit_o
);

  import ni_pkg::*;

  logic [ReqPayloadWidth-1:0] aw_payload;
  logic [ReqPayloadWidth-1:0] w_payload;
  logic [ReqPayloadWidth-1:0] ar_payload;
  logic [ReqFlitWidth-1:0]    wr_flit;
  logic [ReqFlitWidth-1:0]    ar_flit;
  logic                       wr_req;
  logic                       rd_req;
  logic                       wr_win;
  logic                       rd_win;
  logic                       prio_rd_q;
  logic                       flit_fire;

  function automatic logic [ReqFlitWidth-1:0] pack_req(
    input logic [NodeIdWidth-1:0]     dst,
    input logic [NodeIdWidth-1:0]     src,
    input axi_ch_e                    ch,
    input logic [ReqPayloadWidth-1:0] payload
  );
    logic [ReqFlitWidth-1:0] flit;
    flit = '0;
    flit[DstLsb +: NodeIdWidth]         = dst;
    flit[SrcLsb +: NodeIdWidth]         = src;
    flit[ChLsb +: ChWidth]              = ch;
    flit[PayloadLsb +: ReqPayloadWidth] = payload;
    return flit;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Flit packing
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    aw_payload = '0;
    aw_payload[AxAddrLsb +: AddrWidth] = axi_awaddr_i;
    aw_payload[AxProtLsb +: ProtWidth] = axi_awprot_i;
    w_payload = '0;
    w_payload[WDataLsb +: DataWidth] = axi_wdata_i;
    w_payload[WStrbLsb +: StrbWidth] = axi_wstrb_i;
    ar_payload = '0;
    ar_payload[AxAddrLsb +: AddrWidth] = axi_araddr_i;
    ar_payload[AxProtLsb +: ProtWidth] = axi_arprot_i;
  end

  // Write stream offers AW or W depending on the sequencer
  assign wr_flit = (state_i == SelAw) ? pack_req(aw_dst_i, id_i, ChAw, aw_payload)
                                      : pack_req(w_dst_i, id_i, ChW, w_payload);
  assign ar_flit = pack_req(ar_dst_i, id_i, ChAr, ar_payload);

  //////////////////////////////////////////////////////////////////////
  // Arbitration
  //////////////////////////////////////////////////////////////////////

  assign wr_req = (state_i == SelAw) ? (axi_awvalid_i && !wr_stall_i) : axi_wvalid_i;
  assign rd_req = axi_arvalid_i && !rd_stall_i;

  // Between AW and W the read stream is locked out
  assign wr_win = wr_req && (!rd_req || !prio_rd_q || (state_i == SelW));
  assign rd_win = rd_req && !wr_win && (state_i == SelAw);

  assign floo_req_valid_o = wr_win || rd_win;
  assign floo_req_flit_o  = wr_win ? wr_flit : ar_flit;
  assign flit_fire        = floo_req_valid_o && floo_req_ready_i;

  // Next turn goes to the stream that was not just served
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      prio_rd_q <= 1'b0;
    end else if (flit_fire) begin
      prio_rd_q <= wr_win;
    end
  end

  // AXI readies follow the link grant in the same cycle
  assign axi_awready_o = wr_win && (state_i == SelAw) && floo_req_ready_i;
  assign axi_wready_o  = wr_win && (state_i == SelW) && floo_req_ready_i;
  assign axi_arready_o = rd_win && floo_req_ready_i;

  assign aw_fire_o = axi_awvalid_i && axi_awready_o;
  assign w_fire_o  = axi_wvalid_i && axi_wready_o;
  assign ar_fire_o = axi_arvalid_i && axi_arready_o;

endmodule

//--- source/ni_rsp_unpacker.sv
// Response flit unpacker
// Steers response flits to the AXI4-Lite B or R channel by their channel
// field and returns the matching ready to the response link

`timescale 1ns/10ps

module ni_rsp_unpacker (
  input  logic                            floo_rsp_valid_i,
  input  logic [ni_pkg::RspFlitWidth-1:0] floo_rsp_flit_i,
  output logic                            floo_rsp_ready_o,
  output logic                            axi_bvalid_o,
  output logic [ni_pkg::RespWidth-1:0]    axi_bresp_o,
  input  logic                            axi_bready_i,
  output logic                            axi_rvalid_o,
  output logic [ni_pkg::DataWidth-1:0]    axi_rdata_o,
  output logic [ni_pkg::RespWidth-1:0]    axi_rresp_o,
  input  logic                            axi_rready_i
);

  import ni_pkg::*;

  axi_ch_e ch;

  assign ch = axi_ch_e'(floo_rsp_flit_i[ChLsb +: ChWidth]);

  // Valid goes straight through to the selected channel
  assign axi_bvalid_o = floo_rsp_valid_i && (ch == ChB);
  assign axi_rvalid_o = floo_rsp_valid_i && (ch == ChR);

  // Payload fields
  assign axi_bresp_o = floo_rsp_flit_i[PayloadLsb + BRespLsb +: RespWidth];
  assign axi_rdata_o = floo_rsp_flit_i[PayloadLsb + RDataLsb +: DataWidth];
  assign axi_rresp_o = floo_rsp_flit_i[PayloadLsb + RRespLsb +: RespWidth];

  always_comb begin
    case (ch)
      ChB:     floo_rsp_ready_o = axi_bready_i;
      ChR:     floo_rsp_ready_o = axi_rready_i;
      // Stray channels are sunk so the link never blocks
      default: floo_rsp_ready_o = 1'b1;
    endcase
  end

endmodule

//--- source/ni_axi_chimney.sv
// AXI4-Lite NoC chimney, manager side
// Packs AXI4-Lite requests into flits on the request link and unpacks
// response flits into B and R for the local manager

`timescale 1ns/10ps

module ni_axi_chimney (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  // AW channel
  input  logic                            axi_awvalid_i,
  input  logic [ni_pkg::AddrWidth-1:0]    axi_awaddr_i,
  input  logic [ni_pkg::ProtWidth-1:0]    axi_awprot_i,
  output logic                            axi_awready_o,
  // W channel
  input  logic                            axi_wvalid_i,
  input  logic [ni_pkg::DataWidth-1:0]    axi_wdata_i,
  input  logic [ni_pkg::StrbWidth-1:0]    axi_wstrb_i,
  output logic                            axi_wready_o,
  // AR channel
  input  logic                            axi_arvalid_i,
  input  logic [ni_pkg::AddrWidth-1:0]    axi_araddr_i,
  input  logic [ni_pkg::ProtWidth-1:0]    axi_arprot_i,
  output logic                            axi_arready_o,
  // B channel
  output logic                            axi_bvalid_o,
  output logic [ni_pkg::RespWidth-1:0]    axi_bresp_o,
  input  logic                            axi_bready_i,
  // R channel
  output logic                            axi_rvalid_o,
  output logic [ni_pkg::DataWidth-1:0]    axi_rdata_o,
  output logic [ni_pkg::RespWidth-1:0]    axi_rresp_o,
  input  logic                            axi_rready_i,
  // Own node ID
  input  logic [ni_pkg::NodeIdWidth-1:0]  id_i,
  // Request link out
  output logic                            floo_req_valid_o,
  input  logic                            floo_req_ready_i,
  output logic [ni_pkg::ReqFlitWidth-1:0] floo_req_flit_o,
  // Response link in
  input  logic                            floo_rsp_valid_i,
  output logic                            floo_rsp_ready_o,
  input  logic [ni_pkg::RspFlitWidth-1:0] floo_rsp_flit_i
);

  import ni_pkg::*;

  logic [NodeIdWidth-1:0] aw_dst;
  logic [NodeIdWidth-1:0] ar_dst;
  logic [NodeIdWidth-1:0] w_dst;
  logic                   wr_stall;
  logic                   rd_stall;
  aw_w_state_e            state;
  logic                   aw_fire;
  logic                   w_fire;
  logic                   ar_fire;
  logic                   b_fire;
  logic                   r_fire;

  //////////////////////////////////////////////////////////////////////
  // Routing and ordering
  //////////////////////////////////////////////////////////////////////

  ni_addr_decoder u_aw_decoder (
    .addr_i (axi_awaddr_i),
    .dst_o  (aw_dst)
  );

  ni_addr_decoder u_ar_decoder (
    .addr_i (axi_araddr_i),
    .dst_o  (ar_dst)
  );

  // Responses retire the oldest outstanding request
  assign b_fire = axi_bvalid_o && axi_bready_i;
  assign r_fire = axi_rvalid_o && axi_rready_i;

  ni_txn_tracker u_wr_tracker (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .req_fire_i (aw_fire),
    .req_dst_i  (aw_dst),
    .rsp_fire_i (b_fire),
    .stall_o    (wr_stall)
  );

  ni_txn_tracker u_rd_tracker (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .req_fire_i (ar_fire),
    .req_dst_i  (ar_dst),
    .rsp_fire_i (r_fire),
    .stall_o    (rd_stall)
  );

  ni_aw_w_fsm u_aw_w_fsm (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .aw_fire_i (aw_fire),
    .w_fire_i  (w_fire),
    .aw_dst_i  (aw_dst),
    .state_o   (state),
    .w_dst_o   (w_dst)
  );

  //////////////////////////////////////////////////////////////////////
  // Request and response paths
  //////////////////////////////////////////////////////////////////////

  ni_req_arbiter u_req_arbiter (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .id_i             (id_i),
    .axi_awvalid_i    (axi_awvalid_i),
    .axi_awaddr_i     (axi_awaddr_i),
    .axi_awprot_i     (axi_awprot_i),
    .axi_awready_o    (axi_awready_o),
    .axi_wvalid_i     (axi_wvalid_i),
    .axi_wdata_i      (axi_wdata_i),
    .axi_wstrb_i      (axi_wstrb_i),
    .axi_wready_o     (axi_wready_o),
    .axi_arvalid_i    (axi_arvalid_i),
    .axi_araddr_i     (axi_araddr_i),
    .axi_arprot_i     (axi_arprot_i),
    .axi_arready_o    (axi_arready_o),
    .aw_dst_i         (aw_dst),
    .w_dst_i          (w_dst),
    .ar_dst_i         (ar_dst),
    .wr_stall_i       (wr_stall),
    .rd_stall_i       (rd_stall),
    .state_i          (state),
    .aw_fire_o        (aw_fire),
    .w_fire_o         (w_fire),
    .ar_fire_o        (ar_fire),
    .floo_req_valid_o (floo_req_valid_o),
    .floo_req_ready_i (floo_req_ready_i),
    .floo_req_flit_o  (floo_req_flit_o)
  );

  ni_rsp_unpacker u_rsp_unpacker (
    .floo_rsp_valid_i (floo_rsp_valid_i),
    .floo_rsp_flit_i  (floo_rsp_flit_i),
    .floo_rsp_ready_o (floo_rsp_ready_o),
    .axi_bvalid_o     (axi_bvalid_o),
    .axi_bresp_o      (axi_bresp_o),
    .axi_bready_i     (axi_bready_i),
    .axi_rvalid_o     (axi_rvalid_o),
    .axi_rdata_o      (axi_rdata_o),
    .axi_rresp_o      (axi_rresp_o),
    .axi_rready_i     (axi_rready_i)
  );

endmodule

//--- verif/tb_ni_axi_chimney.sv
// Testbench for the AXI4-Lite NoC chimney, manager side
// Directed tests with a request link monitor and a response flit injector

`timescale 1ns/10ps

module tb_ni_axi_chimney;

  import ni_pkg::*;

  localparam int Timeout = 100;
  localparam logic [NodeIdWidth-1:0] NodeId = 4'h3;

  logic                    clk;
  logic                    rst_n_i;
  logic                    axi_awvalid_i;
  logic [AddrWidth-1:0]    axi_awaddr_i;
  logic [ProtWidth-1:0]    axi_awprot_i;
  logic                    axi_awready_o;
  logic                    axi_wvalid_i;
  logic [DataWidth-1:0]    axi_wdata_i;
  logic [StrbWidth-1:0]    axi_wstrb_i;
  logic                    axi_wready_o;
  logic                    axi_arvalid_i;
  logic [AddrWidth-1:0]    axi_araddr_i;
  logic [ProtWidth-1:0]    axi_arprot_i;
  logic                    axi_arready_o;
  logic                    axi_bvalid_o;
  logic [RespWidth-1:0]    axi_bresp_o;
  logic                    axi_bready_i;
  logic                    axi_rvalid_o;
  logic [DataWidth-1:0]    axi_rdata_o;
  logic [RespWidth-1:0]    axi_rresp_o;
  logic                    axi_rready_i;
  logic [NodeIdWidth-1:0]  id_i;
  logic                    floo_req_valid_o;
  logic                    floo_req_ready_i;
  logic [ReqFlitWidth-1:0] floo_req_flit_o;
  logic                    floo_rsp_valid_i;
  logic                    floo_rsp_ready_o;
  logic [RspFlitWidth-1:0] floo_rsp_flit_i;

  logic [ReqFlitWidth-1:0] req_q[$];
  logic [31:0]             lcg_state;
  int                      errors;
  int                      test_err_base;
  int                      tests_run;
  int                      tests_failed;

  ni_axi_chimney u_ni_axi_chimney (.*, .clk_i(clk));

  always #10 clk = ~clk;

  // Link model collects each flit that moves on the next rising edge
  always @(negedge clk) begin
    if (rst_n_i && floo_req_valid_o && floo_req_ready_i) begin
      req_q.push_back(floo_req_flit_o);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // System address map as the chimney must apply it
  function automatic logic [NodeIdWidth-1:0] expected_dst(input logic [31:0] addr);
    if (addr[31:14] != '0) begin
      return 4'hF;
    end
    case (addr[13:12])
      2'd0:    return 4'h1;
      2'd1:    return 4'h2;
      2'd2:    return 4'h5;
      default: return 4'h6;
    endcase
  endfunction

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: %s = %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic timeout_error(input string what);
    $display("ERROR at %0t ns: timed out waiting for %s", $time, what);
    errors++;
  endtask

  task automatic start_test();
    test_err_base = errors;
    tests_run++;
  endtask

  task automatic finish_test(input string name);
    if (errors == test_err_base) begin
      $display("Test %s: ok", name);
    end else begin
      $display("Test %s: failed with %0d errors", name, errors - test_err_base);
      tests_failed++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Manager and link drivers
  //////////////////////////////////////////////////////////////////////

  task automatic write_req(input logic [31:0] addr, input logic [2:0] prot,
                           input logic [31:0] data, input logic [3:0] strb);
    int   cyc;
    logic aw_done;
    logic w_done;
    cyc = 0;
    aw_done = 1'b0;
    w_done = 1'b0;
    @(posedge clk);
    #2;
    axi_awvalid_i = 1'b1;
    axi_awaddr_i = addr;
    axi_awprot_i = prot;
    axi_wvalid_i = 1'b1;
    axi_wdata_i = data;
    axi_wstrb_i = strb;
    while (!(aw_done && w_done) && cyc < Timeout) begin
      @(negedge clk);
      if (axi_awvalid_i && axi_awready_o) begin
        aw_done = 1'b1;
      end
      if (axi_wvalid_i && axi_wready_o) begin
        w_done = 1'b1;
      end
      @(posedge clk);
      #2;
      axi_awvalid_i = axi_awvalid_i && !aw_done;
      axi_wvalid_i = axi_wvalid_i && !w_done;
      cyc++;
    end
    if (!(aw_done && w_done)) begin
      timeout_error("the write handshakes");
    end
  endtask

  task automatic ar_drive(input logic [31:0] addr, input logic [2:0] prot);
    @(posedge clk);
    #2;
    axi_arvalid_i = 1'b1;
    axi_araddr_i = addr;
    axi_arprot_i = prot;
  endtask

  task automatic ar_wait();
    int   cyc;
    logic done;
    cyc = 0;
    done = 1'b0;
    while (!done && cyc < Timeout) begin
      @(negedge clk);
      done = axi_arready_o;
      @(posedge clk);
      #2;
      cyc++;
    end
    axi_arvalid_i = 1'b0;
    if (!done) begin
      timeout_error("arready");
    end
  endtask

  task automatic read_req(input logic [31:0] addr, input logic [2:0] prot);
    ar_drive(addr, prot);
    ar_wait();
  endtask

  // Injects one response flit and checks what the manager sees
  task automatic send_rsp(input axi_ch_e ch, input logic [RspPayloadWidth-1:0] payload);
    int   cyc;
    logic done;
    cyc = 0;
    done = 1'b0;
    @(posedge clk);
    #2;
    floo_rsp_flit_i = '0;
    floo_rsp_flit_i[DstLsb +: NodeIdWidth] = NodeId;
    floo_rsp_flit_i[ChLsb +: ChWidth] = ch;
    floo_rsp_flit_i[PayloadLsb +: RspPayloadWidth] = payload;
    floo_rsp_valid_i = 1'b1;
    while (!done && cyc < Timeout) begin
      @(negedge clk);
      done = floo_rsp_ready_o;
      if (done && ch == ChB) begin
        check("axi_bvalid_o", 64'(axi_bvalid_o), 64'd1);
        check("axi_bresp_o", 64'(axi_bresp_o), 64'(payload[1:0]));
      end else if (done) begin
        check("axi_rvalid_o", 64'(axi_rvalid_o), 64'd1);
        check("axi_rdata_o", 64'(axi_rdata_o), 64'(payload[31:0]));
        check("axi_rresp_o", 64'(axi_rresp_o), 64'(payload[33:32]));
      end
      @(posedge clk);
      #2;
      cyc++;
    end
    floo_rsp_valid_i = 1'b0;
    if (!done) begin
      timeout_error("the response link ready");
    end
  endtask

  task automatic check_req_flit(input logic [ReqFlitWidth-1:0] flit, input axi_ch_e ch,
                                input logic [NodeIdWidth-1:0] dst,
                                input logic [ReqPayloadWidth-1:0] payload);
    check("flit ch", 64'(flit[ChLsb +: ChWidth]), 64'(ch));
    check("flit dst", 64'(flit[DstLsb +: NodeIdWidth]), 64'(dst));
    check("flit src", 64'(flit[SrcLsb +: NodeIdWidth]), 64'(NodeId));
    check("flit payload", 64'(flit[PayloadLsb +: ReqPayloadWidth]), 64'(payload));
  endtask

  // Checks that every AW is directly followed by its W and counts the kinds
  task automatic check_stream(input int base, input int n_wr, input int n_rd);
    int      n_aw;
    int      n_w;
    int      n_ar;
    axi_ch_e ch;
    logic [ChWidth-1:0] next_ch;
    n_aw = 0;
    n_w = 0;
    n_ar = 0;
    for (int i = base; i < req_q.size(); i++) begin
      ch = axi_ch_e'(req_q[i][ChLsb +: ChWidth]);
      if (ch == ChAw) begin
        n_aw++;
        next_ch = (i + 1 < req_q.size()) ? req_q[i+1][ChLsb +: ChWidth] : 3'd7;
        check("flit after AW", 64'(next_ch), 64'(ChW));
      end else if (ch == ChW) begin
        n_w++;
      end else if (ch == ChAr) begin
        n_ar++;
      end
    end
    check("AW flit count", 64'(n_aw), 64'(n_wr));
    check("W flit count", 64'(n_w), 64'(n_wr));
    check("AR flit count", 64'(n_ar), 64'(n_rd));
  endtask

  //////////////////////////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_write();
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0]  strb;
    logic [1:0]  resp;
    int          base;
    start_test();
    base = req_q.size();
    addr = {18'h0, 2'd2, 12'(next_rand() & 32'hFFC)};
    data = next_rand();
    strb = 4'(next_rand());
    resp = 2'b10;
    write_req(addr, 3'd5, data, strb);
    check("write flit count", 64'(req_q.size() - base), 64'd2);
    if (req_q.size() >= base + 2) begin
      check_req_flit(req_q[base], ChAw, expected_dst(addr), {1'b0, 3'd5, addr});
      check_req_flit(req_q[base+1], ChW, expected_dst(addr), {strb, data});
    end
    send_rsp(ChB, {32'h0, resp});
    finish_test("write");
  endtask

  task automatic test_read();
    logic [31:0] addr;
    int          base;
    start_test();
    base = req_q.size();
    addr = {18'h0, 2'd1, 12'(next_rand() & 32'hFFC)};
    read_req(addr, 3'd2);
    check("read flit count", 64'(req_q.size() - base), 64'd1);
    if (req_q.size() > base) begin
      check_req_flit(req_q[base], ChAr, expected_dst(addr), {1'b0, 3'd2, addr});
    end
    send_rsp(ChR, {2'b01, next_rand()});
    finish_test("read");
  endtask

  task automatic test_addr_map();
    logic [31:0] addr;
    int          base;
    start_test();
    for (int i = 0; i < 5; i++) begin
      base = req_q.size();
      addr = (i < 4) ? {18'h0, 2'(i), 12'h40} : 32'h00A0_1000;
      read_req(addr, 3'd0);
      check("address map flit count", 64'(req_q.size() - base), 64'd1);
      if (req_q.size() > base) begin
        check_req_flit(req_q[base], ChAr, expected_dst(addr), {4'h0, addr});
      end
      send_rsp(ChR, {2'b00, next_rand()});
    end
    finish_test("address_map");
  endtask

  task automatic test_stall();
    int base;
    start_test();
    base = req_q.size();
    read_req(32'h0000_0100, 3'd0);
    // Different destination must wait for the first response
    ar_drive(32'h0000_3200, 3'd0);
    repeat (10) begin
      @(negedge clk);
      check("axi_arready_o while stalled", 64'(axi_arready_o), 64'd0);
    end
    send_rsp(ChR, {2'b00, next_rand()});
    ar_wait();
    send_rsp(ChR, {2'b00, next_rand()});
    check("stall flit count", 64'(req_q.size() - base), 64'd2);
    // Four in flight to one node and the fifth waits
    base = req_q.size();
    for (int i = 0; i < 4; i++) begin
      read_req({18'h0, 2'd1, 12'(i * 16)}, 3'd0);
    end
    ar_drive(32'h0000_1100, 3'd0);
    repeat (10) begin
      @(negedge clk);
      check("axi_arready_o at the limit", 64'(axi_arready_o), 64'd0);
    end
    send_rsp(ChR, {2'b00, next_rand()});
    ar_wait();
    repeat (4) send_rsp(ChR, {2'b00, next_rand()});
    check("limit flit count", 64'(req_q.size() - base), 64'd5);
    finish_test("ordering_stall");
  endtask

  task automatic test_backpressure();
    logic [31:0] wa;
    logic [31:0] wd;
    logic [31:0] ra;
    int          hold;
    int          base;
    start_test();
    base = req_q.size();
    wa = {18'h0, 2'd1, 12'(next_rand() & 32'hFFC)};
    wd = next_rand();
    ra = 32'h00A0_0000 | (next_rand() & 32'hFFC);
    hold = 5 + int'(next_rand() % 32'd16);
    @(posedge clk);
    #2;
    floo_req_ready_i = 1'b0;
    fork
      write_req(wa, 3'd1, wd, 4'hF);
      read_req(ra, 3'd2);
      begin
        repeat (hold) begin
          @(negedge clk);
          check("axi_awready_o under back-pressure", 64'(axi_awready_o), 64'd0);
          check("axi_wready_o under back-pressure", 64'(axi_wready_o), 64'd0);
          check("axi_arready_o under back-pressure", 64'(axi_arready_o), 64'd0);
        end
        @(posedge clk);
        #2;
        floo_req_ready_i = 1'b1;
      end
    join
    for (int i = base; i < req_q.size(); i++) begin
      case (axi_ch_e'(req_q[i][ChLsb +: ChWidth]))
        ChAw:    check_req_flit(req_q[i], ChAw, expected_dst(wa), {1'b0, 3'd1, wa});
        ChW:     check_req_flit(req_q[i], ChW, expected_dst(wa), {4'hF, wd});
        default: check_req_flit(req_q[i], ChAr, expected_dst(ra), {1'b0, 3'd2, ra});
      endcase
    end
    check_stream(base, 1, 1);
    send_rsp(ChB, 34'h0);
    send_rsp(ChR, {2'b00, next_rand()});
    finish_test("backpressure");
  endtask

  task automatic test_mixed();
    int base;
    start_test();
    base = req_q.size();
    fork
      for (int i = 0; i < 3; i++) begin
        write_req({18'h0, 2'd2, 12'(i * 16)}, 3'd0, next_rand(), 4'hF);
      end
      for (int j = 0; j < 3; j++) begin
        read_req({18'h0, 2'd3, 12'(j * 16)}, 3'd0);
      end
    join
    check_stream(base, 3, 3);
    repeat (3) send_rsp(ChB, 34'h0);
    repeat (3) send_rsp(ChR, {2'b00, next_rand()});
    finish_test("mixed");
  endtask

  initial begin
    clk = 1'b0;
    rst_n_i = 1'b0;
    axi_awvalid_i = 1'b0;
    axi_awaddr_i = '0;
    axi_awprot_i = '0;
    axi_wvalid_i = 1'b0;
    axi_wdata_i = '0;
    axi_wstrb_i = '0;
    axi_arvalid_i = 1'b0;
    axi_araddr_i = '0;
    axi_arprot_i = '0;
    axi_bready_i = 1'b1;
    axi_rready_i = 1'b1;
    id_i = NodeId;
    floo_req_ready_i = 1'b1;
    floo_rsp_valid_i = 1'b0;
    floo_rsp_flit_i = '0;
    lcg_state = 32'h82190bd5;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    repeat (8) @(posedge clk);
    #2;
    rst_n_i = 1'b1;
    test_write();
    test_read();
    test_addr_map();
    test_stall();
    test_backpressure();
    test_mixed();
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- files.f
source/ni_pkg.sv
source/ni_addr_decoder.sv
source/ni_txn_tracker.sv
source/ni_aw_w_fsm.sv
source/ni_req_arbiter.sv
source/ni_rsp_unpacker.sv
source/ni_axi_chimney.sv
verif/tb_ni_axi_chimney.sv

//--- run_sim.sh
#!/bin/sh
# Build the chimney testbench with Verilator, run it and check the log
rm -rf obj_dir sim.log
verilator --binary --timing --top-module tb_ni_axi_chimney -f files.f -o sim_tb \
  && ./obj_dir/sim_tb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Simulation PASSED" sim.log && echo "Result: pass" || { echo "Result: fail"; exit 1; }
